/* vlog.f */
+incdir+bench
hw/cpuPkg.sv
hw/regFile.sv
hw/controlMain.sv
hw/aluUnit.sv
hw/hazardControl.sv
hw/memAlign.sv
hw/cpuPipeline.sv
bench/cpuBench.sv

/* run.sh */
#!/bin/sh
# Compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cpuBench -o cpuBench
./obj_dir/cpuBench > sim.log 2>&1
cat sim.log
if grep -q "Checks failed" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* bench/programs.svh */
// Test programs for the pipeline testbench
// RV32I instruction encoders and the four directed programs,
// written into the instruction memory model
`ifndef PROGRAMS_SVH
`define PROGRAMS_SVH

localparam int progAlu     = 0;
localparam int progLoadUse = 1;
localparam int progSubWord = 2;
localparam int progBranch  = 3;

int progIdx;

function automatic wordT rType(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
	return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opR};
endfunction

function automatic wordT iType(logic [6:0] op, int rd, logic [2:0] f3, int rs1, int imm);
	return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic wordT sType(logic [2:0] f3, int rs2, int imm, int rs1);
	return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opStore};
endfunction

// Branch offset is in bytes, bit 0 dropped
function automatic wordT bType(logic [2:0] f3, int rs1, int rs2, int imm);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic wordT uType(int rd, int imm20);
	return {imm20[19:0], rd[4:0], opLui};
endfunction

function automatic wordT jType(int rd, int imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
endfunction

task automatic putWord(input wordT w);
	imem[progIdx] = w;
	progIdx++;
endtask

task automatic addImm(input int rd, input int rs1, input int imm);
	putWord(iType(opImm, rd, 3'b000, rs1, imm));
endtask

task automatic regOp(input logic [6:0] f7, input logic [2:0] f3, input int rd,
		input int rs1, input int rs2);
	putWord(rType(f7, f3, rd, rs1, rs2));
endtask

task automatic storeOp(input logic [2:0] f3, input int rs2, input int imm, input int rs1);
	putWord(sType(f3, rs2, imm, rs1));
endtask

task automatic loadOp(input logic [2:0] f3, input int rd, input int imm, input int rs1);
	putWord(iType(opLoad, rd, f3, rs1, imm));
endtask

task automatic branchOp(input logic [2:0] f3, input int rs1, input int rs2, input int imm);
	putWord(bType(f3, rs1, rs2, imm));
endtask

// Lands in the marker area, only reachable on a squashed path
task automatic skippedStore(input int off);
	storeOp(fWord, 0, 'h300 + off, 0);
endtask

// Store to the done address, then spin on a jal to itself
task automatic finishProgram();
	addImm(31, 0, 'h3FC);
	storeOp(fWord, 0, 0, 31);
	putWord(jType(0, 0));
endtask

task automatic loadProgram(input int prog);
	progIdx = 0;
	case (prog)
		progAlu: begin
			addImm(1, 0, 100);
			addImm(2, 0, -7);
			regOp(7'b0, 3'b000, 3, 1, 2);
			regOp(funct7Sub, 3'b000, 4, 3, 1);
			regOp(7'b0, 3'b111, 5, 4, 3);
			regOp(7'b0, 3'b110, 6, 5, 4);
			regOp(7'b0, 3'b100, 7, 6, 3);
			regOp(7'b0, 3'b010, 8, 4, 3);
			regOp(7'b0, 3'b010, 9, 3, 4);
			addImm(11, 8, 2047);
			putWord(uType(12, 'hABCDE));
			addImm(13, 12, -1);
			addImm(10, 0, 'h200);
			for (int k = 3; k <= 9; k++) begin
				storeOp(fWord, k, 4 * (k - 3), 10);
			end
			storeOp(fWord, 11, 28, 10);
			storeOp(fWord, 13, 32, 10);
		end
		progLoadUse: begin
			addImm(10, 0, 'h200);
			addImm(1, 0, 1234);
			storeOp(fWord, 1, 0, 10);
			loadOp(fWord, 2, 0, 10);
			regOp(7'b0, 3'b000, 3, 2, 1);
			storeOp(fWord, 3, 4, 10);
			loadOp(fWord, 4, 4, 10);
			storeOp(fWord, 4, 8, 10);
		end
		progSubWord: begin
			addImm(10, 0, 'h200);
			addImm(11, 0, 'h100);
			putWord(uType(1, 'h12345));
			addImm(1, 1, 'h678);
			for (int k = 0; k < 4; k++) begin
				storeOp(fByte, 1, k, 10);
			end
			storeOp(fHalf, 1, 4, 10);
			storeOp(fHalf, 1, 6, 10);
			loadOp(fByte, 2, 0, 11);
			loadOp(fByteU, 3, 0, 11);
			loadOp(fByte, 4, 1, 11);
			loadOp(fByteU, 5, 3, 11);
			loadOp(fByte, 6, 2, 11);
			loadOp(fHalf, 7, 0, 11);
			loadOp(fHalf, 8, 2, 11);
			loadOp(fHalfU, 9, 2, 11);
			for (int k = 2; k <= 9; k++) begin
				storeOp(fWord, k, 8 + 4 * (k - 2), 10);
			end
		end
		progBranch: begin
			addImm(1, 0, 5);
			addImm(2, 0, 5);
			addImm(3, 0, -3);
			addImm(10, 0, 'h200);
			branchOp(fBeq, 1, 2, 12);
			skippedStore('h00);
			skippedStore('h04);
			branchOp(fBne, 1, 2, 8);
			storeOp(fWord, 1, 0, 10);
			branchOp(fBlt, 3, 1, 12);
			skippedStore('h08);
			skippedStore('h0C);
			branchOp(fBlt, 1, 3, 8);
			storeOp(fWord, 3, 16, 10);
			branchOp(fBeq, 1, 3, 8);
			storeOp(fWord, 2, 20, 10);
			branchOp(fBne, 1, 3, 12);
			skippedStore('h10);
			skippedStore('h14);
			// Word 19, jal over two markers
			putWord(jType(5, 12));
			skippedStore('h18);
			skippedStore('h1C);
			storeOp(fWord, 5, 4, 10);
			addImm(6, 0, 28 * 4);
			// Word 24, jalr to word 28
			putWord(iType(opJalr, 7, 3'b000, 6, 0));
			skippedStore('h20);
			skippedStore('h24);
			skippedStore('h28);
			storeOp(fWord, 7, 8, 10);
		end
		default: ;
	endcase
	finishProgram();
endtask

`endif

/* bench/cpuBench.sv */
`timescale 1ns/1ps
// Testbench for the five-stage pipeline
// Models both caches as memories, runs directed programs with and
// without random cache stalls, and checks every store

module cpuBench import cpuPkg::*; ();

	localparam addrT doneAddr      = 32'h0000_03FC;
	localparam wordT sampleWord    = 32'h80F1_7F82;
	localparam int   timeoutCycles = 4000;

	logic    clock;
	logic    reset = 1'b0;
	logic    icacheStall = 1'b0;
	logic    dcacheStall = 1'b0;
	logic    icacheRen, dcacheRen, dcacheWen;
	addrT    icacheAddr, dcacheAddr;
	byteSelT byteSelectVector;
	wordT    icacheOutput, dcacheOutput, dcacheInput;

	wordT imem [0:255];
	wordT dmem [0:255];

	// Observed and expected stores as address, data and lane triples
	addrT    logAddr[$];
	addrT    expAddr[$];
	wordT    logData[$];
	wordT    expData[$];
	byteSelT logSel[$];
	byteSelT expSel[$];

	logic stallsOn = 1'b0;
	logic doneSeen = 1'b0;
	logic aborted = 1'b0;
	int   seed = 32'h1430;
	int   errorCount = 0;
	int   checkCount = 0;

	`include "programs.svh"

	cpuPipeline cpuPipeline_inst (
		.clock            (clock),
		.reset            (reset),
		.icacheStall      (icacheStall),
		.dcacheStall      (dcacheStall),
		.icacheOutput     (icacheOutput),
		.dcacheOutput     (dcacheOutput),
		.icacheRen        (icacheRen),
		.dcacheRen        (dcacheRen),
		.dcacheWen        (dcacheWen),
		.icacheAddr       (icacheAddr),
		.dcacheAddr       (dcacheAddr),
		.byteSelectVector (byteSelectVector),
		.dcacheInput      (dcacheInput)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Both caches answer in the same cycle
	assign icacheOutput = imem[icacheAddr[9:2]];
	assign dcacheOutput = dmem[dcacheAddr[9:2]];

	always @(posedge clock) begin
		if (stallsOn && reset) begin
			icacheStall <= ($random(seed) & 3) == 0;
			dcacheStall <= ($random(seed) & 3) == 0;
		end else begin
			icacheStall <= 1'b0;
			dcacheStall <= 1'b0;
		end
	end

	function automatic wordT laneMask(byteSelT sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	// Data cache writes only on an unfrozen edge
	always @(posedge clock) begin
		if (reset && dcacheWen && !icacheStall && !dcacheStall) begin
			if (dcacheAddr == doneAddr) begin
				doneSeen = 1'b1;
			end else begin
				dmem[dcacheAddr[9:2]] = (dmem[dcacheAddr[9:2]] & ~laneMask(byteSelectVector)) |
					(dcacheInput & laneMask(byteSelectVector));
				logAddr.push_back(dcacheAddr);
				logData.push_back(dcacheInput);
				logSel.push_back(byteSelectVector);
			end
		end
	end

	function automatic wordT signByte(logic [7:0] b);
		return b[7] ? {24'hFF_FFFF, b} : {24'h0, b};
	endfunction

	function automatic wordT signHalf(logic [15:0] h);
		return h[15] ? {16'hFFFF, h} : {16'h0, h};
	endfunction

	task automatic fillMemories();
		for (int i = 0; i < 256; i++) begin
			// addi x0, x0, i is a NOP that still carries its address
			imem[i] = iType(opImm, 0, 3'b000, 0, i);
			dmem[i] = (i * 32'h0101_0101) ^ 32'hC3A5_5A3C;
		end
		dmem[32'h100 >> 2] = sampleWord;
	endtask

	task automatic expectStore(input addrT a, input wordT d, input byteSelT s);
		expAddr.push_back(a);
		expData.push_back(d);
		expSel.push_back(s);
	endtask

	task automatic checkResetState();
		checkCount++;
		assert (!dcacheRen && !dcacheWen && icacheRen && icacheAddr == 32'h0) else begin
			errorCount++;
			$display("FAIL %0t: after reset ren=%b wen=%b iren=%b icacheAddr=%h", $time,
				dcacheRen, dcacheWen, icacheRen, icacheAddr);
		end
	endtask

	task automatic runProgram(input int prog, input logic withStalls);
		int waited;
		if (aborted) begin
			return;
		end
		@(posedge clock);
		reset <= 1'b0;
		stallsOn <= withStalls;
		fillMemories();
		loadProgram(prog);
		logAddr.delete();
		logData.delete();
		logSel.delete();
		doneSeen = 1'b0;
		repeat (5) @(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		checkResetState();
		waited = 0;
		while (!doneSeen && waited < timeoutCycles) begin
			@(negedge clock);
			waited++;
		end
		if (!doneSeen) begin
			errorCount++;
			aborted = 1'b1;
			$display("Timeout: program %0d never stored to the done address", prog);
		end
	endtask

	task automatic compareLog(input string tag);
		wordT mask;
		if (aborted) begin
			return;
		end
		checkCount++;
		assert (logAddr.size() == expAddr.size()) else begin
			errorCount++;
			$display("FAIL %0t: %s logged %0d stores, expected %0d", $time, tag,
				logAddr.size(), expAddr.size());
		end
		for (int i = 0; i < logAddr.size() && i < expAddr.size(); i++) begin
			mask = laneMask(expSel[i]);
			checkCount++;
			assert (logAddr[i] == expAddr[i] && logSel[i] == expSel[i] &&
				(logData[i] & mask) == (expData[i] & mask)) else begin
				errorCount++;
				$display("FAIL %0t: %s store %0d got %h/%h/%b, expected %h/%h/%b", $time,
					tag, i, logAddr[i], logData[i], logSel[i], expAddr[i], expData[i], expSel[i]);
			end
		end
	endtask

	// Unstalled run against the ISA values and a stalled rerun against its log
	task automatic verifyProgram(input int prog, input string name);
		runProgram(prog, 1'b0);
		compareLog({name, " unstalled"});
		expAddr = logAddr;
		expData = logData;
		expSel = logSel;
		runProgram(prog, 1'b1);
		compareLog({name, " stalled"});
		expAddr.delete();
		expData.delete();
		expSel.delete();
	endtask

	task automatic aluChain();
		wordT a, b, c, d, e, f, g, lt1, lt2;
		a = 32'd100;
		b = 32'hFFFF_FFF9;
		c = a + b;
		d = c - a;
		e = d & c;
		f = e | d;
		g = f ^ c;
		lt1 = ($signed(d) < $signed(c)) ? 32'd1 : 32'd0;
		lt2 = ($signed(c) < $signed(d)) ? 32'd1 : 32'd0;
		expectStore(32'h200, c, 4'hF);
		expectStore(32'h204, d, 4'hF);
		expectStore(32'h208, e, 4'hF);
		expectStore(32'h20C, f, 4'hF);
		expectStore(32'h210, g, 4'hF);
		expectStore(32'h214, lt1, 4'hF);
		expectStore(32'h218, lt2, 4'hF);
		expectStore(32'h21C, lt1 + 32'd2047, 4'hF);
		expectStore(32'h220, (32'hABCDE << 12) - 32'd1, 4'hF);
		verifyProgram(progAlu, "ALU chain");
	endtask

	task automatic loadUseHazard();
		expectStore(32'h200, 32'd1234, 4'hF);
		expectStore(32'h204, 32'd2468, 4'hF);
		expectStore(32'h208, 32'd2468, 4'hF);
		verifyProgram(progLoadUse, "load-use");
	endtask

	task automatic subWordAccess();
		wordT val;
		val = (32'h12345 << 12) + 32'h678;
		for (int k = 0; k < 4; k++) begin
			expectStore(32'h200 + k, {4{val[7:0]}}, 4'b0001 << k);
		end
		expectStore(32'h204, {2{val[15:0]}}, 4'b0011);
		expectStore(32'h206, {2{val[15:0]}}, 4'b1100);
		expectStore(32'h208, signByte(sampleWord[7:0]), 4'hF);
		expectStore(32'h20C, {24'h0, sampleWord[7:0]}, 4'hF);
		expectStore(32'h210, signByte(sampleWord[15:8]), 4'hF);
		expectStore(32'h214, {24'h0, sampleWord[31:24]}, 4'hF);
		expectStore(32'h218, signByte(sampleWord[23:16]), 4'hF);
		expectStore(32'h21C, signHalf(sampleWord[15:0]), 4'hF);
		expectStore(32'h220, signHalf(sampleWord[31:16]), 4'hF);
		expectStore(32'h224, {16'h0, sampleWord[31:16]}, 4'hF);
		verifyProgram(progSubWord, "sub-word");
	endtask

	task automatic controlFlow();
		int jalPc;
		int jalrPc;
		jalPc = 19 * 4;
		jalrPc = 24 * 4;
		expectStore(32'h200, 32'd5, 4'hF);
		expectStore(32'h210, 32'hFFFF_FFFD, 4'hF);
		expectStore(32'h214, 32'd5, 4'hF);
		// Link registers hold the jump PC plus 4
		expectStore(32'h204, jalPc + 4, 4'hF);
		expectStore(32'h208, jalrPc + 4, 4'hF);
		verifyProgram(progBranch, "control flow");
	endtask

	initial begin
		aluChain();
		loadUseHazard();
		subWordAccess();
		controlFlow();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* hw/cpuPipeline.sv */
`timescale 1ns/1ps
// Five-stage RV32I integer pipeline
// IF, ID, EX, MEM and WB with forwarding, a load-use stall, jal
// resolved in decode, branches and jalr resolved in memory, and a
// global freeze whenever either cache stalls

module cpuPipeline import cpuPkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    icacheStall,
	input  logic    dcacheStall,
	input  wordT    icacheOutput,
	input  wordT    dcacheOutput,
	output logic    icacheRen,
	output logic    dcacheRen,
	output logic    dcacheWen,
	output addrT    icacheAddr,
	output addrT    dcacheAddr,
	output byteSelT byteSelectVector,
	output wordT    dcacheInput
);

	logic stall;
	logic holdFront, bubbleIfId, bubbleIdEx, bubbleExMem, redirect;
	logic [1:0] fwdA, fwdB;

	// Fetch
	addrT pc, pcNext;

	// IF/ID
	addrT ifIdPc;
	wordT ifIdInstr;

	// Decode outputs
	regAddrT idRs1, idRs2, idRd;
	logic idRegWrite, idMemRead, idMemWrite, idMemToReg, idAluSrc;
	logic idBranch, idJump, idJumpReg, idAInIsPc;
	aluClassT idAluClass;
	wordT idImm, idRs1Data, idRs2Data;
	addrT jalTarget;

	// ID/EX
	logic idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg, idExAluSrc;
	logic idExBranch, idExJump, idExJumpReg, idExAInIsPc;
	aluClassT idExAluClass;
	logic [2:0] idExFunct3;
	logic [6:0] idExFunct7;
	regAddrT idExRs1, idExRs2, idExRd;
	addrT idExPc;
	wordT idExRs1Data, idExRs2Data, idExImm;

	// Execute
	wordT bypassA, bypassB, aluInA, aluInB, aluOut;
	addrT targetBase, exTarget;
	logic aluZero, aluLess;

	// EX/MEM
	logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg;
	logic exMemBranch, exMemJumpReg, exMemZero, exMemLess;
	logic [2:0] exMemFunct3;
	regAddrT exMemRd;
	wordT exMemAlu, exMemStoreData;
	addrT exMemTarget;
	logic branchTaken;
	wordT memLoadValue;

	// MEM/WB
	logic memWbRegWrite, memWbMemToReg;
	regAddrT memWbRd;
	wordT memWbAlu, memWbLoad, wbData;

	assign stall = icacheStall || dcacheStall;

	// Instruction fetch
	assign pcNext = redirect ? exMemTarget :
		idJump ? jalTarget : pc + 32'd4;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= resetPc;
		end else if (!stall && !holdFront) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ifIdInstr <= nopInstr;
		end else if (!stall) begin
			if (bubbleIfId) begin
				ifIdInstr <= nopInstr;
			end else if (!holdFront) begin
				ifIdInstr <= icacheOutput;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!stall && !holdFront) begin
			ifIdPc <= pc;
		end
	end

	// Instruction decode
	assign idRs1 = ifIdInstr[19:15];
	assign idRs2 = ifIdInstr[24:20];
	assign idRd  = ifIdInstr[11:7];

	controlMain controlMain_inst (
		.instr     (ifIdInstr),
		.regWrite  (idRegWrite),
		.memRead   (idMemRead),
		.memWrite  (idMemWrite),
		.memToReg  (idMemToReg),
		.aluSrc    (idAluSrc),
		.branch    (idBranch),
		.jump      (idJump),
		.jumpReg   (idJumpReg),
		.aInIsPc   (idAInIsPc),
		.aluClass  (idAluClass),
		.immediate (idImm)
	);

	// Writes are held off during a freeze
	regFile regFile_inst (
		.clock       (clock),
		.reset       (reset),
		.readAddrA   (idRs1),
		.readAddrB   (idRs2),
		.writeAddr   (memWbRd),
		.writeEnable (memWbRegWrite && !stall),
		.writeData   (wbData),
		.readDataA   (idRs1Data),
		.readDataB   (idRs2Data)
	);

	assign jalTarget = ifIdPc + idImm;

	hazardControl hazardControl_inst (
		.idRs1       (idRs1),
		.idRs2       (idRs2),
		.exRs1       (idExRs1),
		.exRs2       (idExRs2),
		.exRd        (idExRd),
		.memRd       (exMemRd),
		.wbRd        (memWbRd),
		.exMemRead   (idExMemRead),
		.memRegWrite (exMemRegWrite),
		.wbRegWrite  (memWbRegWrite),
		.jump        (idJump),
		.redirect    (redirect),
		.holdFront   (holdFront),
		.bubbleIfId  (bubbleIfId),
		.bubbleIdEx  (bubbleIdEx),
		.bubbleExMem (bubbleExMem),
		.fwdA        (fwdA),
		.fwdB        (fwdB)
	);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <= '0;
			{idExAluSrc, idExBranch, idExJump, idExJumpReg, idExAInIsPc} <= '0;
			idExAluClass <= classAdd;
			idExFunct3   <= '0;
			idExFunct7   <= '0;
			idExRs1      <= zeroReg;
			idExRs2      <= zeroReg;
			idExRd       <= zeroReg;
		end else if (!stall) begin
			if (bubbleIdEx) begin
				{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <= '0;
				{idExAluSrc, idExBranch, idExJump, idExJumpReg, idExAInIsPc} <= '0;
				idExAluClass <= classAdd;
				idExRd       <= zeroReg;
			end else begin
				idExRegWrite <= idRegWrite;
				idExMemRead  <= idMemRead;
				idExMemWrite <= idMemWrite;
				idExMemToReg <= idMemToReg;
				idExAluSrc   <= idAluSrc;
				idExBranch   <= idBranch;
				idExJump     <= idJump;
				idExJumpReg  <= idJumpReg;
				idExAInIsPc  <= idAInIsPc;
				idExAluClass <= idAluClass;
				idExRd       <= idRd;
			end
			idExFunct3 <= ifIdInstr[14:12];
			idExFunct7 <= ifIdInstr[31:25];
			idExRs1    <= idRs1;
			idExRs2    <= idRs2;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			idExPc      <= ifIdPc;
			idExRs1Data <= idRs1Data;
			idExRs2Data <= idRs2Data;
			idExImm     <= idImm;
		end
	end

	// Execute
	assign bypassA = (fwdA == fwdMem) ? exMemAlu :
		(fwdA == fwdWb) ? wbData : idExRs1Data;
	assign bypassB = (fwdB == fwdMem) ? exMemAlu :
		(fwdB == fwdWb) ? wbData : idExRs2Data;

	assign aluInA = idExAInIsPc ? idExPc : bypassA;
	// Jumps add 4 to the PC for the link value
	assign aluInB = (idExJump || idExJumpReg) ? 32'd4 :
		idExAluSrc ? idExImm : bypassB;

	aluUnit aluUnit_inst (
		.inA      (aluInA),
		.inB      (aluInB),
		.aluClass (idExAluClass),
		.funct3   (idExFunct3),
		.funct7   (idExFunct7),
		.result   (aluOut),
		.zero     (aluZero),
		.lessThan (aluLess)
	);

	// Branch or jalr target with bit 0 cleared as jalr requires
	assign targetBase = idExJumpReg ? bypassA : idExPc;
	assign exTarget   = (targetBase + idExImm) & ~32'd1;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			{exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg} <= '0;
			exMemBranch  <= 1'b0;
			exMemJumpReg <= 1'b0;
			exMemFunct3  <= '0;
			exMemRd      <= zeroReg;
		end else if (!stall) begin
			if (bubbleExMem) begin
				{exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg} <= '0;
				exMemBranch  <= 1'b0;
				exMemJumpReg <= 1'b0;
				exMemFunct3  <= '0;
				exMemRd      <= zeroReg;
			end else begin
				exMemRegWrite <= idExRegWrite;
				exMemMemRead  <= idExMemRead;
				exMemMemWrite <= idExMemWrite;
				exMemMemToReg <= idExMemToReg;
				exMemBranch   <= idExBranch;
				exMemJumpReg  <= idExJumpReg;
				exMemFunct3   <= idExFunct3;
				exMemRd       <= idExRd;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			exMemAlu       <= aluOut;
			exMemStoreData <= bypassB;
			exMemTarget    <= exTarget;
			exMemZero      <= aluZero;
			exMemLess      <= aluLess;
		end
	end

	// Memory access and branch resolution
	always_comb begin
		case (exMemFunct3)
			fBeq:    branchTaken = exMemBranch && exMemZero;
			fBne:    branchTaken = exMemBranch && !exMemZero;
			fBlt:    branchTaken = exMemBranch && exMemLess;
			default: branchTaken = 1'b0;
		endcase
	end

	assign redirect = branchTaken || exMemJumpReg;

	memAlign memAlign_inst (
		.storeData    (exMemStoreData),
		.storeFunct3  (exMemFunct3),
		.storeOffset  (exMemAlu[1:0]),
		.loadWord     (dcacheOutput),
		.loadFunct3   (exMemFunct3),
		.loadOffset   (exMemAlu[1:0]),
		.alignedStore (dcacheInput),
		.byteSelect   (byteSelectVector),
		.loadValue    (memLoadValue)
	);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			memWbRegWrite <= 1'b0;
			memWbMemToReg <= 1'b0;
			memWbRd       <= zeroReg;
		end else if (!stall) begin
			memWbRegWrite <= exMemRegWrite;
			memWbMemToReg <= exMemMemToReg;
			memWbRd       <= exMemRd;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			memWbAlu  <= exMemAlu;
			memWbLoad <= memLoadValue;
		end
	end

	// Writeback
	assign wbData = memWbMemToReg ? memWbLoad : memWbAlu;

	// Cache ports
	assign icacheAddr = pc;
	assign icacheRen  = !holdFront;
	assign dcacheAddr = exMemAlu;
	assign dcacheRen  = exMemMemRead;
	assign dcacheWen  = exMemMemWrite;

endmodule

/* hw/memAlign.sv */
`timescale 1ns/1ps
// Data memory lane alignment
// Store side replicates the byte or half across lanes and enables
// the addressed ones; load side extracts and extends

module memAlign import cpuPkg::*; (
	input  wordT       storeData,
	input  logic [2:0] storeFunct3,
	input  logic [1:0] storeOffset,
	input  wordT       loadWord,
	input  logic [2:0] loadFunct3,
	input  logic [1:0] loadOffset,
	output wordT       alignedStore,
	output byteSelT    byteSelect,
	output wordT       loadValue
);

	logic [7:0]  loadByte;
	logic [15:0] loadHalf;

	always_comb begin
		case (storeFunct3)
			fByte: begin
				alignedStore = {4{storeData[7:0]}};
				byteSelect   = 4'b0001 << storeOffset;
			end
			fHalf: begin
				alignedStore = {2{storeData[15:0]}};
				byteSelect   = storeOffset[1] ? 4'b1100 : 4'b0011;
			end
			fWord: begin
				alignedStore = storeData;
				byteSelect   = 4'b1111;
			end
			default: begin
				alignedStore = storeData;
				byteSelect   = 4'b0000;
			end
		endcase
	end

	assign loadByte = loadWord[8*loadOffset +: 8];
	assign loadHalf = loadOffset[1] ? loadWord[31:16] : loadWord[15:0];

	always_comb begin
		case (loadFunct3)
			fByte:   loadValue = {{24{loadByte[7]}}, loadByte};
			fHalf:   loadValue = {{16{loadHalf[15]}}, loadHalf};
			fByteU:  loadValue = {24'b0, loadByte};
			fHalfU:  loadValue = {16'b0, loadHalf};
			default: loadValue = loadWord;
		endcase
	end

endmodule

/* hw/hazardControl.sv */
`timescale 1ns/1ps
// Hazard unit
// Load-use detection, flush bubbles for jal and for redirects
// out of the memory stage, and EX operand bypass selects

module hazardControl import cpuPkg::*; (
	input  regAddrT    idRs1,
	input  regAddrT    idRs2,
	input  regAddrT    exRs1,
	input  regAddrT    exRs2,
	input  regAddrT    exRd,
	input  regAddrT    memRd,
	input  regAddrT    wbRd,
	input  logic       exMemRead,
	input  logic       memRegWrite,
	input  logic       wbRegWrite,
	input  logic       jump,
	input  logic       redirect,
	output logic       holdFront,
	output logic       bubbleIfId,
	output logic       bubbleIdEx,
	output logic       bubbleExMem,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB
);

	logic loadUse;

	// Youngest producer wins, x0 never forwards
	function automatic logic [1:0] pickSource(regAddrT rs);
		if (memRegWrite && memRd != zeroReg && memRd == rs) begin
			return fwdMem;
		end else if (wbRegWrite && wbRd != zeroReg && wbRd == rs) begin
			return fwdWb;
		end
		return fwdReg;
	endfunction

	// A jal in ID reads no registers, its fields are immediate bits
	assign loadUse = exMemRead && exRd != zeroReg && !jump &&
		(idRs1 == exRd || idRs2 == exRd);

	// Redirect outranks the stall since ID is discarded anyway
	assign holdFront   = loadUse && !redirect;
	assign bubbleIfId  = redirect || jump;
	assign bubbleIdEx  = redirect || loadUse;
	assign bubbleExMem = redirect;

	assign fwdA = pickSource(exRs1);
	assign fwdB = pickSource(exRs2);

endmodule

/* hw/aluUnit.sv */
`timescale 1ns/1ps
// ALU with its own control
// Maps the decoded class and function fields to an operation,
// and flags zero and signed less-than for branch resolution

module aluUnit import cpuPkg::*; (
	input  wordT       inA,
	input  wordT       inB,
	input  aluClassT   aluClass,
	input  logic [2:0] funct3,
	input  logic [6:0] funct7,
	output wordT       result,
	output logic       zero,
	output logic       lessThan
);

	aluOpT op;

	always_comb begin
		case (aluClass)
			classAdd:    op = opAdd;
			classBranch: op = opSub;
			classLui:    op = opPassB;
			default: begin
				// Register and immediate ops share funct3
				case (funct3)
					3'b000:  op = (aluClass == classReg && funct7 == funct7Sub) ? opSub : opAdd;
					3'b010:  op = opSlt;
					3'b100:  op = opXor;
					3'b110:  op = opOr;
					3'b111:  op = opAnd;
					default: op = opAdd;
				endcase
			end
		endcase
	end

	assign lessThan = $signed(inA) < $signed(inB);

	always_comb begin
		case (op)
			opSub:   result = inA - inB;
			opAnd:   result = inA & inB;
			opOr:    result = inA | inB;
			opXor:   result = inA ^ inB;
			opSlt:   result = {31'b0, lessThan};
			opPassB: result = inB;
			default: result = inA + inB;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* hw/controlMain.sv */
`timescale 1ns/1ps
// Main decoder
// Turns the opcode into stage controls and picks the immediate
// format that belongs to the instruction

module controlMain import cpuPkg::*; (
	input  wordT     instr,
	output logic     regWrite,
	output logic     memRead,
	output logic     memWrite,
	output logic     memToReg,
	output logic     aluSrc,
	output logic     branch,
	output logic     jump,
	output logic     jumpReg,
	output logic     aInIsPc,
	output aluClassT aluClass,
	output wordT     immediate
);

	logic [6:0] opcode;
	wordT immI;
	wordT immS;
	wordT immB;
	wordT immU;
	wordT immJ;

	assign opcode = instr[6:0];

	// Immediate formats
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		regWrite  = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		memToReg  = 1'b0;
		aluSrc    = 1'b0;
		branch    = 1'b0;
		jump      = 1'b0;
		jumpReg   = 1'b0;
		aInIsPc   = 1'b0;
		aluClass  = classAdd;
		immediate = '0;
		case (opcode)
			opR: begin
				regWrite = 1'b1;
				aluClass = classReg;
			end
			opImm: begin
				regWrite  = 1'b1;
				aluSrc    = 1'b1;
				aluClass  = classImm;
				immediate = immI;
			end
			opLoad: begin
				regWrite  = 1'b1;
				memRead   = 1'b1;
				memToReg  = 1'b1;
				aluSrc    = 1'b1;
				immediate = immI;
			end
			opStore: begin
				memWrite  = 1'b1;
				aluSrc    = 1'b1;
				immediate = immS;
			end
			opBranch: begin
				branch    = 1'b1;
				aluClass  = classBranch;
				immediate = immB;
			end
			// Link value PC+4 comes out of the ALU
			opJal: begin
				regWrite  = 1'b1;
				jump      = 1'b1;
				aInIsPc   = 1'b1;
				immediate = immJ;
			end
			opJalr: begin
				regWrite  = 1'b1;
				jumpReg   = 1'b1;
				aInIsPc   = 1'b1;
				immediate = immI;
			end
			opLui: begin
				regWrite  = 1'b1;
				aluSrc    = 1'b1;
				aluClass  = classLui;
				immediate = immU;
			end
			default: ;  // anything else behaves as a NOP
		endcase
	end

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps
// Integer register file
// Two read ports, one write port, x0 hardwired to zero,
// and a same-cycle write passed through to the readers

module regFile import cpuPkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  regAddrT readAddrA,
	input  regAddrT readAddrB,
	input  regAddrT writeAddr,
	input  logic    writeEnable,
	input  wordT    writeData,
	output wordT    readDataA,
	output wordT    readDataB
);

	wordT regs [1:regCount-1];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != zeroReg) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Writeback and decode share a cycle, so bypass the write
	assign readDataA = (readAddrA == zeroReg) ? '0 :
		(writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == zeroReg) ? '0 :
		(writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

/* hw/cpuPkg.sv */
// CPU package
// Shared widths, opcodes, ALU encodings and register-file constants
// for the five-stage RV32I pipeline

package cpuPkg;

	// Data and address widths
	typedef logic [31:0] wordT;
	typedef logic [31:0] addrT;
	typedef logic [4:0]  regAddrT;
	typedef logic [3:0]  byteSelT;

	// Operations the ALU can perform
	typedef enum logic [2:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opSlt,
		opPassB
	} aluOpT;

	// ALU class chosen by decode, refined later with funct3/funct7
	typedef enum logic [2:0] {
		classAdd,
		classReg,
		classImm,
		classLui,
		classBranch
	} aluClassT;

	// Major opcodes
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opLui    = 7'b0110111;

	// Memory access width
	localparam logic [2:0] fByte  = 3'b000;
	localparam logic [2:0] fHalf  = 3'b001;
	localparam logic [2:0] fWord  = 3'b010;
	localparam logic [2:0] fByteU = 3'b100;
	localparam logic [2:0] fHalfU = 3'b101;

	// Branch conditions
	localparam logic [2:0] fBeq = 3'b000;
	localparam logic [2:0] fBne = 3'b001;
	localparam logic [2:0] fBlt = 3'b100;

	// funct7 that turns add into sub
	localparam logic [6:0] funct7Sub = 7'b0100000;

	localparam addrT resetPc  = 32'h0000_0000;
	localparam wordT nopInstr = 32'h0000_0013;  // addi x0, x0, 0

	// Register file
	localparam int      regCount = 32;
	localparam regAddrT zeroReg  = 5'd0;

	// Operand bypass sources
	localparam logic [1:0] fwdReg = 2'd0;
	localparam logic [1:0] fwdWb  = 2'd1;
	localparam logic [1:0] fwdMem = 2'd2;

endpackage
